// File: Makefile
# Verilator build for the codec control block and its testbench

TOP     ?= tb_codec_ctrl
RTL_TOP ?= codec_ctrl_top
SRC_F   ?= src.f
BUILD   ?= obj_dir
VFLAGS  ?= --binary --timing --assert -Wno-fatal
LFLAGS  ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	verilator $(LFLAGS) -f $(SRC_F) --top-module $(RTL_TOP)
	verilator $(LFLAGS) -f $(SRC_F) --top-module $(TOP)

sim:
	verilator $(VFLAGS) -f $(SRC_F) --top-module $(TOP) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: src.f
src/codec_reg_pkg.sv
src/wb_bus_pkg.sv
src/codec_wb_slave.sv
src/codec_init_seq.sv
src/codec_spi_master.sv
src/codec_ctrl_top.sv
test/tb_codec_ctrl.sv

// File: src/codec_ctrl_top.sv
// Codec control top: Wishbone slave, init sequencer and serial master
`timescale 1ns/1ps

module codec_ctrl_top #(
    parameter codec_reg_pkg::init_profile_e INIT_PROFILE = codec_reg_pkg::PROF_NO_IAMP,
    parameter int                           SCLK_HALF    = 2
) (
    input  logic                            clk,
    input  logic                            rst,
    input  wb_bus_pkg::wb_req_t             wb_i,
    output logic [wb_bus_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                            ack_o,
    output logic                            sclk_o,
    output logic                            sdio_o,
    input  logic                            sdo_i,
    output logic                            sen_n_o,
    output logic [7:0]                      dataout_o,
    output logic                            init_done_o
);

    logic                        cmd_valid;         // Bus command strobe
    codec_reg_pkg::codec_frame_t cmd_frame;
    logic                        path_busy;         // Holds off bus acks
    logic                        spi_start;
    codec_reg_pkg::codec_frame_t spi_frame;
    logic                        spi_busy;

    codec_wb_slave i_wb_slave (
        .clk         (clk),
        .rst         (rst),
        .wb_i        (wb_i),
        .wb_dat_o    (wb_dat_o),
        .ack_o       (ack_o),
        .path_busy_i (path_busy),
        .cmd_valid_o (cmd_valid),
        .cmd_frame_o (cmd_frame)
    );

    codec_init_seq #(
        .INIT_PROFILE (INIT_PROFILE)
    ) i_init_seq (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid),
        .cmd_frame_i (cmd_frame),
        .spi_busy_i  (spi_busy),
        .start_o     (spi_start),
        .frame_o     (spi_frame),
        .path_busy_o (path_busy),
        .init_done_o (init_done_o)
    );

    codec_spi_master #(
        .SCLK_HALF (SCLK_HALF)
    ) i_spi_master (
        .clk       (clk),
        .rst       (rst),
        .start_i   (spi_start),
        .frame_i   (spi_frame),
        .sdo_i     (sdo_i),
        .sclk_o    (sclk_o),
        .sdio_o    (sdio_o),
        .sen_n_o   (sen_n_o),
        .busy_o    (spi_busy),
        .dataout_o (dataout_o)
    );

endmodule

// File: src/codec_init_seq.sv
// Codec init sequencer: sends the enabled init table entries, then forwards bus commands
`timescale 1ns/1ps

module codec_init_seq #(
    parameter codec_reg_pkg::init_profile_e INIT_PROFILE = codec_reg_pkg::PROF_NO_IAMP
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cmd_valid_i,
    input  codec_reg_pkg::codec_frame_t cmd_frame_i,
    input  logic                        spi_busy_i,
    output logic                        start_o,
    output codec_reg_pkg::codec_frame_t frame_o,
    output logic                        path_busy_o,
    output logic                        init_done_o
);

    localparam codec_reg_pkg::init_table_t TABLE = codec_reg_pkg::init_table(INIT_PROFILE);
    localparam logic [4:0] LAST = 5'(codec_reg_pkg::INIT_LEN - 1);

    logic [4:0]                 ptr;                // Table entry, also register address
    logic                       init_done_q;
    logic                       guard_q;            // Start issued last cycle
    logic                       master_free;
    logic                       init_step;
    codec_reg_pkg::init_entry_t entry;

    assign entry = TABLE[ptr];

    // Busy from the master lags start by one cycle, guard covers it
    assign master_free = !spi_busy_i && !guard_q;

    // Disabled entries skip in one cycle, enabled ones wait for the master
    assign init_step = !init_done_q && (!entry.wr_en || master_free);

    always_comb begin
        if (init_done_q) begin
            start_o = cmd_valid_i;                  // Bus command straight through
            frame_o = cmd_frame_i;
        end else begin
            start_o = entry.wr_en && master_free;
            frame_o = codec_reg_pkg::codec_frame(ptr, entry.value);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ptr         <= 5'd0;
            init_done_q <= 1'b0;
            guard_q     <= 1'b0;
        end else begin
            guard_q <= start_o;
            if (init_step) begin
                if (ptr == LAST) begin
                    init_done_q <= 1'b1;            // Table finished
                end else begin
                    ptr <= ptr + 5'd1;
                end
            end
        end
    end

    assign path_busy_o = !init_done_q || spi_busy_i || guard_q;
    assign init_done_o = init_done_q;

    // Bus slave only commits commands on a free path
    a_cmd_when_free: assert property (@(posedge clk) disable iff (rst)
        cmd_valid_i |-> !path_busy_o);

endmodule

// File: src/codec_reg_pkg.sv
// Codec register map: serial frame layout, init table profiles and RX PGA gain coding
package codec_reg_pkg;

    localparam int INIT_LEN = 20;                   // Init table spans 0x00 to 0x13

    localparam logic [4:0] REG_RX_GAIN = 5'h09;     // RX PGA gain register
    localparam logic [4:0] REG_TX_GAIN = 5'h0a;     // TX gain register

    // One serial frame, shifted out MSB first
    typedef struct packed {
        logic [2:0] hdr;                            // Read flag and width, zero for writes
        logic [4:0] addr;                           // Codec register address
        logic [7:0] data;                           // Register value
    } codec_frame_t;

    typedef struct packed {
        logic       wr_en;                          // Entry is sent during init
        logic [7:0] value;
    } init_entry_t;

    typedef init_entry_t [INIT_LEN-1:0] init_table_t;   // Index equals register address

    typedef enum logic [1:0] {
        PROF_REGULAR,                               // Interpolating TX, RX filter on
        PROF_NO_INTERP,                             // No interpolation, no clock divide
        PROF_2X_OSC,                                // Oscillator multiplied by two
        PROF_NO_IAMP                                // IAMP off, RX filter off
    } init_profile_e;

    // Write frame for a register
    function automatic codec_frame_t codec_frame(input logic [4:0] addr,
                                                 input logic [7:0] data);
        codec_frame_t f;
        f.hdr  = 3'b000;
        f.addr = addr;
        f.data = data;
        return f;
    endfunction

    function automatic init_table_t init_table(input init_profile_e prof);
        init_table_t t;
        t = '0;                                     // Disabled unless listed below
        case (prof)
            PROF_REGULAR: begin
                t[5'h07] = '{1'b1, 8'h21};          // DC offset cal, RX filter on
                t[5'h08] = '{1'b1, 8'h4b};          // RX filter corner
                t[5'h0b] = '{1'b1, 8'h20};          // RX gain on PGA only
                t[5'h0c] = '{1'b1, 8'h41};          // TX twos complement, interpolation
                t[5'h0d] = '{1'b1, 8'h01};          // RX twos complement
                t[5'h11] = '{1'b1, 8'h00};          // TX gain select
            end
            PROF_NO_INTERP: begin
                t[5'h00] = '{1'b1, 8'h80};          // Four wire serial port
                t[5'h04] = '{1'b1, 8'h00};          // No oscillator multiply
                t[5'h06] = '{1'b1, 8'h00};          // No FPGA clock divide
                t[5'h07] = '{1'b1, 8'h21};
                t[5'h08] = '{1'b1, 8'h4b};
                t[5'h0b] = '{1'b1, 8'h20};
                t[5'h0c] = '{1'b1, 8'h81};          // Interpolation bypassed
                t[5'h0d] = '{1'b1, 8'h01};
                t[5'h11] = '{1'b1, 8'h00};
            end
            PROF_2X_OSC: begin
                t[5'h00] = '{1'b1, 8'h80};
                t[5'h04] = '{1'b1, 8'h16};          // Oscillator times two
                t[5'h07] = '{1'b1, 8'h21};
                t[5'h08] = '{1'b1, 8'h4b};
                t[5'h0b] = '{1'b1, 8'h20};
                t[5'h0c] = '{1'b1, 8'h41};
                t[5'h0d] = '{1'b1, 8'h01};
                t[5'h11] = '{1'b1, 8'h00};
            end
            default: begin                          // PROF_NO_IAMP
                t[5'h05] = '{1'b1, 8'h01};
                t[5'h07] = '{1'b1, 8'h20};          // DC offset cal, RX filter off
                t[5'h0b] = '{1'b1, 8'h00};          // No PGA gain
                t[5'h0c] = '{1'b1, 8'h43};
                t[5'h0d] = '{1'b1, 8'h03};
                t[5'h0e] = '{1'b1, 8'h81};          // IAMP disabled
                t[5'h10] = '{1'b1, 8'h80};
                t[5'h11] = '{1'b1, 8'h00};
                t[5'h12] = '{1'b1, 8'h00};
            end
        endcase
        return t;
    endfunction

    // Bus gain to PGA code, bit 6 selects direct coding
    function automatic logic [5:0] rx_gain_code(input logic [6:0] gain);
        logic [5:0] code;
        if (gain[6]) begin
            code = gain[5:0];
        end else if (gain[5]) begin
            code = ~gain[5:0];                      // Upper half folds back
        end else begin
            code = {1'b1, gain[4:0]};
        end
        return code;
    endfunction

endpackage

// File: src/codec_spi_master.sv
// Codec serial master: shifts 16-bit frames out on sdio and captures sdo
`timescale 1ns/1ps

module codec_spi_master #(
    parameter int SCLK_HALF = 2                     // Clocks per sclk half period
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start_i,
    input  codec_reg_pkg::codec_frame_t frame_i,
    input  logic                        sdo_i,
    output logic                        sclk_o,
    output logic                        sdio_o,
    output logic                        sen_n_o,
    output logic                        busy_o,
    output logic [7:0]                  dataout_o
);

    localparam int DIV_W = (SCLK_HALF > 1) ? $clog2(SCLK_HALF) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCLK_HALF - 1);

    typedef enum logic [1:0] {
        IDLE,                                       // Enable high, waiting for start
        LOW,                                        // First half of a bit, sclk low
        HIGH                                        // Second half, sclk high
    } state_e;

    state_e           state;
    logic [DIV_W-1:0] div_cnt;                      // Clocks into the half period
    logic [3:0]       bit_cnt;                      // Bits left after this one
    logic [15:0]      shift_q;                      // Out at MSB, sdo in at LSB
    logic             sclk_q;
    logic             sen_n_q;
    logic             half_end;

    assign half_end = (div_cnt == DIV_LAST);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            div_cnt <= '0;
            bit_cnt <= 4'd0;
            sclk_q  <= 1'b0;
            sen_n_q <= 1'b1;
        end else begin
            div_cnt <= (state == IDLE || half_end) ? '0 : div_cnt + 1'b1;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        state   <= LOW;
                        sen_n_q <= 1'b0;            // Enable low on the next clock
                        bit_cnt <= 4'd15;
                    end
                end
                LOW: begin
                    if (half_end) begin
                        state  <= HIGH;
                        sclk_q <= 1'b1;             // Rise mid bit
                    end
                end
                HIGH: begin
                    if (half_end) begin
                        sclk_q <= 1'b0;
                        if (bit_cnt == 4'd0) begin
                            state   <= IDLE;
                            sen_n_q <= 1'b1;        // Frame done
                        end else begin
                            state   <= LOW;
                            bit_cnt <= bit_cnt - 4'd1;
                        end
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Next bit out and sdo in on the sclk fall
    always_ff @(posedge clk) begin
        if (state == IDLE && start_i) begin
            shift_q <= frame_i;
        end else if (state == HIGH && half_end) begin
            shift_q <= {shift_q[14:0], sdo_i};
        end
    end

    assign sclk_o    = sclk_q;
    assign sen_n_o   = sen_n_q;
    assign sdio_o    = shift_q[15];
    assign busy_o    = (state != IDLE);
    assign dataout_o = shift_q[7:0];                // Last received byte after a frame

    // Clock idles low outside a frame
    a_sclk_idle_low: assert property (@(posedge clk) disable iff (rst)
        sen_n_o |-> !sclk_o);

endmodule

// File: src/codec_wb_slave.sv
// Codec bus slave: turns Wishbone gain and register writes into serial frame commands
`timescale 1ns/1ps

module codec_wb_slave (
    input  logic                            clk,
    input  logic                            rst,
    input  wb_bus_pkg::wb_req_t             wb_i,
    output logic [wb_bus_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                            ack_o,
    input  logic                            path_busy_i,
    output logic                            cmd_valid_o,
    output codec_reg_pkg::codec_frame_t     cmd_frame_o
);

    typedef enum logic {
        IDLE,                                       // Waiting for a request
        ACK                                         // Ack and command strobe
    } state_e;

    state_e                      state;
    logic [3:0]                  tx_gain;           // Last TX gain sent
    logic [3:0]                  tx_gain_nxt;
    logic [6:0]                  rx_gain;           // Last RX gain sent
    logic [6:0]                  rx_gain_nxt;
    logic                        accept;
    logic                        dec_valid;         // Accepted request needs a frame
    codec_reg_pkg::codec_frame_t dec_frame;
    logic                        cmd_pend;
    codec_reg_pkg::codec_frame_t cmd_frame_q;

    // Stall by holding off the ack while the serial path is busy
    assign accept = (state == IDLE) && wb_i.cyc && wb_i.stb && !path_busy_i;

    always_comb begin
        tx_gain_nxt = tx_gain;
        rx_gain_nxt = rx_gain;
        dec_valid   = 1'b0;
        dec_frame   = codec_reg_pkg::codec_frame(wb_i.dat[20:16], wb_i.dat[7:0]);
        if (wb_i.we) begin                          // Reads only get an ack
            case (wb_i.adr)
                wb_bus_pkg::WB_ADR_TX_GAIN: begin
                    tx_gain_nxt = wb_i.dat[31:28];
                    dec_valid   = (tx_gain_nxt != tx_gain);     // Only on change
                    dec_frame   = codec_reg_pkg::codec_frame(codec_reg_pkg::REG_TX_GAIN,
                                                             {4'b0100, tx_gain_nxt});
                end
                wb_bus_pkg::WB_ADR_RX_GAIN: begin
                    rx_gain_nxt = wb_i.dat[6:0];
                    dec_valid   = (rx_gain_nxt != rx_gain);
                    dec_frame   = codec_reg_pkg::codec_frame(codec_reg_pkg::REG_RX_GAIN,
                                      {2'b01, codec_reg_pkg::rx_gain_code(rx_gain_nxt)});
                end
                wb_bus_pkg::WB_ADR_CODEC: begin
                    dec_valid = (wb_i.dat[31:24] == wb_bus_pkg::CODEC_WR_KEY);
                end
                default: begin
                    dec_valid = 1'b0;               // Unmapped, ack only
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            tx_gain  <= 4'h0;
            rx_gain  <= 7'h40;                      // Direct PGA code, zero gain
            cmd_pend <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state    <= ACK;
                        cmd_pend <= dec_valid;
                        tx_gain  <= tx_gain_nxt;    // Shadows track every write
                        rx_gain  <= rx_gain_nxt;
                    end
                end
                default: begin
                    state    <= IDLE;               // Ack lasts one cycle
                    cmd_pend <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_frame_q <= dec_frame;
        end
    end

    assign ack_o       = (state == ACK);
    assign cmd_valid_o = ack_o && cmd_pend;
    assign cmd_frame_o = cmd_frame_q;
    assign wb_dat_o    = '0;                        // No readable registers

    // Command strobe only while the accepted write is still held on the bus
    a_cmd_on_write: assert property (@(posedge clk) disable iff (rst)
        cmd_valid_o |-> wb_i.cyc && wb_i.stb && wb_i.we);

endmodule

// File: src/wb_bus_pkg.sv
// Wishbone bus definitions: request bundle, slave address map and generic write key
package wb_bus_pkg;

    localparam int WB_ADR_W = 6;                    // Word address bits
    localparam int WB_DAT_W = 32;

    // Master to slave signals of one Wishbone request
    typedef struct packed {
        logic                cyc;                   // Bus cycle in progress
        logic                stb;                   // Request strobe
        logic                we;                    // Write when high
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wb_req_t;

    // TX gain in dat[31:28]
    localparam logic [WB_ADR_W-1:0] WB_ADR_TX_GAIN = 6'h09;

    // RX gain in dat[6:0]
    localparam logic [WB_ADR_W-1:0] WB_ADR_RX_GAIN = 6'h0a;

    // Key in dat[31:24], register in dat[20:16], value in dat[7:0]
    localparam logic [WB_ADR_W-1:0] WB_ADR_CODEC = 6'h3b;

    localparam logic [7:0] CODEC_WR_KEY = 8'h06;    // Guards generic codec writes

endpackage

// File: test/tb_codec_ctrl.sv
// Codec control testbench: Wishbone driver, serial slave model and in-order frame checker
`timescale 1ns/1ps

module tb_codec_ctrl;

    localparam int SCLK_HALF    = 2;
    localparam int EXP_FRAMES   = 9 + 12 + 20 + 6;          // Upper bound on frames sent
    localparam int FRAME_CYC    = 16 * 2 * SCLK_HALF;       // Clocks per serial frame
    localparam int WATCHDOG_CYC = (EXP_FRAMES + 20) * FRAME_CYC * 2;

    logic                        clk = 1'b0;
    logic                        rst;
    wb_bus_pkg::wb_req_t         wb;
    logic [31:0]                 wb_dat;
    logic                        ack;
    logic                        sclk;
    logic                        sdio;
    logic                        sdo;
    logic                        sen_n;
    logic [7:0]                  dataout;
    logic                        init_done;

    logic [31:0]                 stim_lfsr = 32'h9c04;      // Bus stimulus stream
    logic [31:0]                 sdo_lfsr  = 32'h9c04;      // Serial slave stream
    logic [3:0]                  tx_shadow = 4'h0;          // Expected DUT gain state
    logic [6:0]                  rx_shadow = 7'h40;
    codec_reg_pkg::codec_frame_t exp_q[$];                  // Frames still to arrive
    logic [15:0]                 got_q[$];                  // Frames seen on sdio
    logic [7:0]                  sent_q[$];                 // Last sdo byte per frame
    int                          n_starts = 0;              // Frames begun on sen_n

    always #20 clk = ~clk;                                  // 40 ns period

    codec_ctrl_top #(
        .INIT_PROFILE (codec_reg_pkg::PROF_NO_IAMP),
        .SCLK_HALF    (SCLK_HALF)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .wb_i        (wb),
        .wb_dat_o    (wb_dat),
        .ack_o       (ack),
        .sclk_o      (sclk),
        .sdio_o      (sdio),
        .sdo_i       (sdo),
        .sen_n_o     (sen_n),
        .dataout_o   (dataout),
        .init_done_o (init_done)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL t=%0t %s: got 0x%0h, expected 0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);               // One step per bit
            v = {v[30:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // Bus word with a key byte on top of 24 random bits
    function automatic logic [31:0] keyed_word(input logic [7:0] key);
        logic [31:0] r;
        r = rand_bits(24);
        return {key, r[23:0]};
    endfunction

    // Frame a bus access should cause, tracks the gain shadows
    function automatic logic expected_frame(input logic we, input logic [5:0] adr,
                                            input logic [31:0] dat,
                                            output codec_reg_pkg::codec_frame_t f);
        logic hit;
        hit = 1'b0;
        f   = '0;
        if (we && adr == wb_bus_pkg::WB_ADR_TX_GAIN) begin
            hit       = (dat[31:28] != tx_shadow);          // Only on change
            tx_shadow = dat[31:28];
            f         = {3'b000, codec_reg_pkg::REG_TX_GAIN, 4'b0100, dat[31:28]};
        end else if (we && adr == wb_bus_pkg::WB_ADR_RX_GAIN) begin
            hit       = (dat[6:0] != rx_shadow);
            rx_shadow = dat[6:0];
            f = {3'b000, codec_reg_pkg::REG_RX_GAIN, 2'b01, codec_reg_pkg::rx_gain_code(dat[6:0])};
        end else if (we && adr == wb_bus_pkg::WB_ADR_CODEC) begin
            hit = (dat[31:24] == wb_bus_pkg::CODEC_WR_KEY);  // Key guarded
            f   = {3'b000, dat[20:16], dat[7:0]};
        end
        return hit;
    endfunction

    // One Wishbone access, held until ack
    task automatic bus_access(input logic we, input logic [5:0] adr, input logic [31:0] dat);
        codec_reg_pkg::codec_frame_t f;
        if (expected_frame(we, adr, dat, f)) begin
            exp_q.push_back(f);
        end
        @(posedge clk);
        wb <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        @(posedge clk);
        while (ack !== 1'b1) begin
            @(posedge clk);                                 // Stalled while path busy
        end
        check_eq("wb_dat_o", wb_dat, 32'h0);
        wb <= '0;
    endtask

    task automatic drain_frames();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (FRAME_CYC + 8) @(posedge clk);              // Room for a stray frame
    endtask

    always @(negedge sen_n) begin
        n_starts++;                                         // Enable drops, frame begins
    end

    // Serial slave, captures sdio and answers on sdo at each sclk rise
    initial begin : serial_model
        logic [15:0] rx;
        logic [7:0]  sent;
        int          nbits;
        rx    = '0;
        sent  = '0;
        nbits = 0;
        sdo   = 1'b0;
        forever begin
            @(posedge sclk);
            if (sen_n === 1'b0) begin
                rx       = {rx[14:0], sdio};
                sdo_lfsr = lfsr_step(sdo_lfsr);
                sdo     <= sdo_lfsr[0];                     // Sampled on the sclk fall
                sent     = {sent[6:0], sdo_lfsr[0]};
                nbits++;
                if (nbits == 16) begin
                    got_q.push_back(rx);
                    sent_q.push_back(sent);
                    nbits = 0;
                end
            end
        end
    end

    // In-order frame and readback check at each frame end
    initial begin : compare_frames
        logic [15:0]                 got;
        codec_reg_pkg::codec_frame_t want;
        @(negedge rst);
        forever begin
            @(posedge sen_n);
            @(negedge clk);                                 // dataout settled
            if (got_q.size() == 0) begin
                abort_run($sformatf("Frame ended at %0t with fewer than 16 sclk pulses", $time));
            end
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
                abort_run($sformatf("Unexpected frame 0x%04h at %0t", got, $time));
            end
            want = exp_q.pop_front();
            check_eq("sdio frame", 32'(got), 32'(want));
            check_eq("dataout_o", 32'(dataout), 32'(sent_q.pop_front()));
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYC) @(posedge clk);
        abort_run("Timeout: the DUT stopped acknowledging or sending frames");
    end

    initial begin : stimulus
        codec_reg_pkg::init_table_t tbl;
        logic [31:0]                v;
        int                         n_init;
        rst    = 1'b1;
        wb     = '0;
        n_init = 0;
        tbl    = codec_reg_pkg::init_table(codec_reg_pkg::PROF_NO_IAMP);
        for (int a = 0; a < codec_reg_pkg::INIT_LEN; a++) begin
            if (tbl[a].wr_en) begin                         // Enabled entries in address order
                exp_q.push_back({3'b000, 5'(a), tbl[a].value});
                n_init++;
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_eq("sen_n_o", 32'(sen_n), 32'h1);
        check_eq("sclk_o", 32'(sclk), 32'h0);
        check_eq("ack_o", 32'(ack), 32'h0);
        while (init_done !== 1'b1) begin
            @(posedge clk);
        end
        check_eq("frames started before init_done_o", 32'(n_starts), 32'(n_init));
        drain_frames();
        for (int i = 0; i < 12; i++) begin                  // TX gain in bits 31:28
            v = rand_bits(32);
            bus_access(1'b1, wb_bus_pkg::WB_ADR_TX_GAIN, v);
        end
        bus_access(1'b1, wb_bus_pkg::WB_ADR_TX_GAIN, v);    // Same gain, no frame
        drain_frames();
        for (int i = 0; i < 20; i++) begin
            v = rand_bits(32);
            bus_access(1'b1, wb_bus_pkg::WB_ADR_RX_GAIN, v);
        end
        bus_access(1'b1, wb_bus_pkg::WB_ADR_RX_GAIN, v);
        drain_frames();
        for (int i = 0; i < 6; i++) begin
            v = keyed_word(wb_bus_pkg::CODEC_WR_KEY);
            bus_access(1'b1, wb_bus_pkg::WB_ADR_CODEC, v);
        end
        bus_access(1'b1, wb_bus_pkg::WB_ADR_CODEC, keyed_word(8'h07));     // Bad key
        bus_access(1'b1, 6'h20, keyed_word(wb_bus_pkg::CODEC_WR_KEY));     // Unmapped
        bus_access(1'b0, wb_bus_pkg::WB_ADR_TX_GAIN, rand_bits(32));       // Reads
        bus_access(1'b0, wb_bus_pkg::WB_ADR_CODEC, keyed_word(wb_bus_pkg::CODEC_WR_KEY));
        drain_frames();
        $display("TB PASSED");
        $finish;
    end

endmodule
